//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_us_top
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0 --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build $(TOP) with $(VERILATOR) and run it"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- src.f
+incdir+tb
verilog/us_pkg.sv
verilog/us_byte_fifo.sv
verilog/us_arbiter.sv
verilog/us_framer.sv
verilog/us_top.sv
tb/tb_us_top.sv

//--- tb/tb_us_tasks.svh
// tasks of tb_us_top, included in its body; relies on the DUT nets and byte models there

// x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

task automatic rand_byte(output logic [7:0] b);
  b = 8'h00;
  for (int i = 0; i < 8; i++) begin
    lfsr = lfsr_next(lfsr);  // one step per bit
    b = {b[6:0], lfsr[0]};
  end
endtask

task automatic check(input string name, input logic [31:0] exp_v, input logic [31:0] act_v);
  if (exp_v !== act_v) begin
    $display("Error: %s expected %0h actual %0h", name, exp_v, act_v);
    $display("Verification failed");
    $fatal(1, "stopped at first mismatch");
  end
endtask

task automatic load_fifo(input int kind, input int n);
  logic [7:0] b;
  for (int i = 0; i < n; i++) begin
    rand_byte(b);
    @(posedge clk);
    if (kind == k_iq) begin
      iq_wr    <= 1'b1;
      iq_wdata <= b;
      iq_model.push_back(b);
    end else begin
      spec_wr    <= 1'b1;
      spec_wdata <= b;
      spec_model.push_back(b);
    end
  end
  @(posedge clk);
  iq_wr   <= 1'b0;
  spec_wr <= 1'b0;
endtask

task automatic set_run(input logic v);
  @(posedge clk);
  run <= v;
  if (!v) begin
    iq_seq_m   = '0;  // both counters clear while run is low
    spec_seq_m = '0;
  end
endtask

task automatic wait_request();
  @(negedge clk);
  while (!udp_tx_request) @(negedge clk);
endtask

task automatic expect_quiet(input string name, input int n);
  repeat (n) begin
    @(negedge clk);
    check(name, 32'd0, 32'(udp_tx_request));
  end
endtask

// header byte at idx; streaming payload bytes come from the models instead
function automatic logic [7:0] layout_byte(input int kind, input int idx, input logic [31:0] seq);
  if (idx == 0) return 8'hef;
  if (idx == 1) return 8'hfe;
  if (kind == k_disc) begin
    if (idx == 2) return run ? 8'h03 : 8'h02;
    if (idx <= 8) return mac[8*(8-idx) +: 8];  // msb first
    if (idx == 9) return serial_no;
    if (idx == 10) return board_id;
    if (idx == 11) return assign_nr;
    return 8'h00;
  end
  if (idx == 2) return 8'h01;
  if (idx == 3) return (kind == k_iq) ? 8'h06 : 8'h04;
  return seq[8*(7-idx) +: 8];  // big-endian seq in idx 4 to 7
endfunction

function automatic int next_stream();
  return last_iq_m ? k_spec : k_iq;
endfunction

task automatic receive_frame(input string name, input int kind, input int delay);
  logic [7:0]  exp_b;
  logic [31:0] seq;
  int          len;
  len = (kind == k_disc) ? 60 : 8 + payload_len;
  seq = (kind == k_spec) ? spec_seq_m : iq_seq_m;
  wait_request();
  check({name, " length"}, 32'(len), 32'(udp_tx_length));
  repeat (delay) begin  // MAC back-pressure
    @(negedge clk);
    check({name, " held request"}, 32'd1, 32'(udp_tx_request));
    check({name, " held length"}, 32'(len), 32'(udp_tx_length));
  end
  @(posedge clk);
  udp_tx_enable <= 1'b1;
  @(posedge clk);
  udp_tx_enable <= 1'b0;
  for (int i = 0; i < len; i++) begin
    @(negedge clk);
    if (i == 0) check({name, " request drop"}, 32'd0, 32'(udp_tx_request));
    if (kind != k_disc && i >= 8)
      exp_b = (kind == k_iq) ? iq_model.pop_front() : spec_model.pop_front();
    else
      exp_b = layout_byte(kind, i, seq);
    check($sformatf("%s byte %0d", name, i), 32'(exp_b), 32'(udp_tx_data));
  end
  if (kind == k_iq) begin
    iq_seq_m++;
    last_iq_m = 1'b1;
  end else if (kind == k_spec) begin
    spec_seq_m++;
    last_iq_m = 1'b0;
  end
endtask

task automatic test_discovery();
  for (int r = 0; r < 2; r++) begin
    set_run(r == 1);
    @(posedge clk);
    discovery <= 1'b1;
    wait_request();
    @(posedge clk);
    discovery <= 1'b0;  // grant is already latched
    receive_frame((r == 1) ? "disc run high" : "disc run low", k_disc, 0);
  end
endtask

task automatic test_iq_frames();
  set_run(1'b1);
  load_fifo(k_iq, payload_len - 1);
  expect_quiet("iq below payload", 20);
  load_fifo(k_iq, 1);
  receive_frame("iq frame 0", k_iq, 0);
  for (int f = 1; f < 3; f++) begin
    load_fifo(k_iq, payload_len);
    receive_frame($sformatf("iq frame %0d", f), k_iq, f);
  end
endtask

task automatic test_spec_frames();
  @(posedge clk);
  wide_spectrum <= 1'b1;
  for (int f = 0; f < 2; f++) begin
    load_fifo(k_spec, payload_len);
    receive_frame($sformatf("spec frame %0d", f), k_spec, 0);
  end
  @(posedge clk);
  wide_spectrum <= 1'b0;
  load_fifo(k_spec, payload_len);  // left in the FIFO for arbitration
  expect_quiet("spec disabled", 20);
endtask

task automatic test_arbitration();
  set_run(1'b0);
  load_fifo(k_iq, 2 * payload_len);
  load_fifo(k_spec, payload_len);
  @(posedge clk);
  run           <= 1'b1;
  wide_spectrum <= 1'b1;
  wait_request();
  @(posedge clk);
  discovery <= 1'b1;  // raised while a stream frame waits
  receive_frame("arb stream 0", next_stream(), 0);
  wait_request();
  @(posedge clk);
  discovery <= 1'b0;
  receive_frame("arb disc", k_disc, 0);
  for (int f = 1; f < 4; f++)
    receive_frame($sformatf("arb stream %0d", f), next_stream(), 0);
endtask

task automatic test_backpressure_run();
  @(posedge clk);
  wide_spectrum <= 1'b0;
  load_fifo(k_iq, payload_len);
  receive_frame("bp iq", k_iq, 30);
  set_run(1'b0);
  repeat (3) @(posedge clk);
  set_run(1'b1);
  load_fifo(k_iq, payload_len);
  receive_frame("run clear iq", k_iq, 0);
  @(posedge clk);
  wide_spectrum <= 1'b1;
  load_fifo(k_spec, payload_len);
  receive_frame("run clear spec", k_spec, 0);
endtask

//--- tb/tb_us_top.sv
// directed testbench for us_top with 64-byte payloads and the default FIFO depth
module tb_us_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int payload_len = 64;
  localparam int max_cycles  = 20000;  // whole sequence needs roughly 3000 cycles
  localparam int k_disc      = 1;
  localparam int k_iq        = 2;
  localparam int k_spec      = 3;

  logic        clk;
  logic        rst_n;
  logic        run;
  logic        wide_spectrum;
  logic        discovery;
  logic [47:0] mac;
  logic [7:0]  serial_no;
  logic [7:0]  board_id;
  logic [7:0]  assign_nr;
  logic        iq_wr;
  logic [7:0]  iq_wdata;
  logic        spec_wr;
  logic [7:0]  spec_wdata;
  logic        udp_tx_enable;
  logic        udp_tx_request;
  logic [7:0]  udp_tx_data;
  logic [10:0] udp_tx_length;

  logic [31:0] lfsr;
  logic [7:0]  iq_model[$];    // bytes still expected out of each FIFO
  logic [7:0]  spec_model[$];
  logic [31:0] iq_seq_m;
  logic [31:0] spec_seq_m;
  logic        last_iq_m;      // last stream frame was I/Q
  int          cycles  = 0;

  us_top #(.payload_len(payload_len)) i_us_top (
    .clk, .rst_n, .run, .wide_spectrum, .discovery, .mac, .serial_no, .board_id,
    .assign_nr, .iq_wr, .iq_wdata, .spec_wr, .spec_wdata, .udp_tx_enable,
    .udp_tx_request, .udp_tx_data, .udp_tx_length
  );

  `include "tb_us_tasks.svh"

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("Verification failed");
      $fatal(1, "run timed out after %0d cycles", cycles);
    end
  end

  initial begin
    rst_n         <= 1'b0;
    run           <= 1'b0;
    wide_spectrum <= 1'b0;
    discovery     <= 1'b0;
    mac           <= 48'h00_1c_c0_a2_13_5f;
    serial_no     <= 8'h4a;
    board_id      <= 8'h06;
    assign_nr     <= 8'h91;
    iq_wr         <= 1'b0;
    iq_wdata      <= 8'h00;
    spec_wr       <= 1'b0;
    spec_wdata    <= 8'h00;
    udp_tx_enable <= 1'b0;
    lfsr       = 32'h2d82acbc;
    iq_seq_m   = '0;
    spec_seq_m = '0;
    last_iq_m  = 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    repeat (4) @(posedge clk);
    test_discovery();
    test_iq_frames();
    test_spec_frames();
    test_arbitration();
    test_backpressure_run();
    repeat (4) @(posedge clk);
    $display("Verification passed");
    $finish;
  end

endmodule

//--- verilog/us_arbiter.sv
// picks the next frame class while the framer is idle; grant is a registered one-cycle pulse
module us_arbiter import us_pkg::*; #(
  parameter int payload_len = 1024
) (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         discovery,
  input  logic         run,
  input  logic         wide_spectrum,
  input  logic [11:0]  iq_level,
  input  logic [11:0]  spec_level,
  input  logic         busy,
  output frame_grant_t grant
);

  localparam logic [10:0] stream_len = 11'(hdr_bytes + payload_len);

  frame_grant_t grant_d;
  logic         iq_ok;
  logic         spec_ok;
  logic         free;
  logic         last_iq;  // last stream grant went to I/Q

  assign iq_ok   = run && (iq_level >= 12'(payload_len));
  assign spec_ok = wide_spectrum && (spec_level >= 12'(payload_len));

  // busy rises one cycle after the grant, so hold off while the pulse is out
  assign free = !busy && (grant.kind == kind_none);

  always_comb begin
    grant_d = '{kind: kind_none, length: 11'd0};
    if (free) begin
      if (discovery)
        grant_d = '{kind: kind_disc, length: 11'(disc_bytes)};
      else if (iq_ok && (!spec_ok || !last_iq))  // round-robin when both eligible
        grant_d = '{kind: kind_iq, length: stream_len};
      else if (spec_ok)
        grant_d = '{kind: kind_spec, length: stream_len};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      grant   <= '{kind: kind_none, length: 11'd0};
      last_iq <= 1'b0;
    end else begin
      grant <= grant_d;
      if (grant_d.kind == kind_iq) last_iq <= 1'b1;
      else if (grant_d.kind == kind_spec) last_iq <= 1'b0;
    end
  end

  // framer must still be idle when the grant lands
  a_no_grant_busy: assert property (@(posedge clk) disable iff (!rst_n)
    (grant.kind != kind_none) |-> !busy)
    else $error("grant issued while framer busy");

endmodule

//--- verilog/us_byte_fifo.sv
// single-clock show-ahead byte FIFO; depth 2**fifo_depth_log2 must not exceed 2048 (12-bit level)
module us_byte_fifo #(
  parameter int fifo_depth_log2 = 11
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        wr,
  input  logic [7:0]  wdata,
  input  logic        rd,
  output logic [7:0]  rd_data,
  output logic [11:0] level
);

  localparam int depth = 1 << fifo_depth_log2;

  logic [7:0]                 mem [depth];
  logic [fifo_depth_log2-1:0] wr_ptr;
  logic [fifo_depth_log2-1:0] rd_ptr;
  logic                       full;
  logic                       empty;
  logic                       push;
  logic                       pop;

  assign full  = (level == 12'(depth));
  assign empty = (level == 12'd0);
  assign push  = wr && !full;   // a push into a full FIFO is dropped
  assign pop   = rd && !empty;

  assign rd_data = mem[rd_ptr];  // oldest byte, no read latency

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= wdata;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   level <= level + 12'd1;
        2'b01:   level <= level - 12'd1;
        default: level <= level;
      endcase
    end
  end

  // the framer pops only after the arbiter has seen a full payload
  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
    rd |-> !empty)
    else $error("rd pulsed on empty FIFO");

  // producers are expected to watch the level
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    wr |-> !full)
    else $error("wr pulsed on full FIFO");

endmodule

//--- verilog/us_framer.sv
// frame sender; the MAC cannot stall once enable is taken, so payload must already sit in the FIFO
module us_framer import us_pkg::*; #(
  parameter int payload_len = 1024
) (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         run,
  input  logic [47:0]  mac,
  input  logic [7:0]   serial_no,
  input  logic [7:0]   board_id,
  input  logic [7:0]   assign_nr,
  input  frame_grant_t grant,
  output logic         busy,
  input  logic         udp_tx_enable,
  output logic         udp_tx_request,
  output logic [7:0]   udp_tx_data,
  output logic [10:0]  udp_tx_length,
  input  logic [7:0]   iq_rd_data,
  input  logic [7:0]   spec_rd_data,
  output logic         iq_rd,
  output logic         spec_rd
);

  typedef enum logic [1:0] {
    st_idle,
    st_request,
    st_send
  } state_t;

  state_t       state;
  frame_grant_t cur;        // grant latched for the whole frame
  logic [10:0]  byte_cnt;   // index of the byte now on udp_tx_data
  logic [10:0]  next_idx;
  logic         last_byte;
  logic         pay_phase;
  logic [31:0]  iq_seq;
  logic [31:0]  spec_seq;
  logic [31:0]  seq;
  logic [7:0]   ep_byte;
  logic [7:0]   pay_byte;
  logic [7:0]   next_byte;
  logic [7:0]   data_q;

  assign next_idx  = byte_cnt + 11'd1;
  assign last_byte = (byte_cnt == cur.length - 11'd1);

  assign seq      = (cur.kind == kind_spec) ? spec_seq : iq_seq;
  assign ep_byte  = (cur.kind == kind_spec) ? ep_spec : ep_iq;
  assign pay_byte = (cur.kind == kind_spec) ? spec_rd_data : iq_rd_data;

  // pop while the payload byte goes into data_q
  assign pay_phase = (state == st_send) && !last_byte && (next_idx >= 11'(hdr_bytes));
  assign iq_rd     = pay_phase && (cur.kind == kind_iq);
  assign spec_rd   = pay_phase && (cur.kind == kind_spec);

  assign busy           = (state != st_idle);
  assign udp_tx_request = (state == st_request);
  assign udp_tx_length  = cur.length;
  assign udp_tx_data    = data_q;

  // byte for index next_idx; index 0 is loaded while waiting for enable
  always_comb begin
    if (cur.kind == kind_disc) begin
      case (next_idx)
        11'd1:   next_byte = sync_lo;
        11'd2:   next_byte = run ? 8'h03 : 8'h02;  // status
        11'd3:   next_byte = mac[47:40];
        11'd4:   next_byte = mac[39:32];
        11'd5:   next_byte = mac[31:24];
        11'd6:   next_byte = mac[23:16];
        11'd7:   next_byte = mac[15:8];
        11'd8:   next_byte = mac[7:0];
        11'd9:   next_byte = serial_no;
        11'd10:  next_byte = board_id;
        11'd11:  next_byte = assign_nr;
        default: next_byte = 8'h00;  // zero padding
      endcase
    end else begin
      case (next_idx)
        11'd1:   next_byte = sync_lo;
        11'd2:   next_byte = 8'h01;
        11'd3:   next_byte = ep_byte;
        11'd4:   next_byte = seq[31:24];  // big-endian sequence
        11'd5:   next_byte = seq[23:16];
        11'd6:   next_byte = seq[15:8];
        11'd7:   next_byte = seq[7:0];
        default: next_byte = pay_byte;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= st_idle;
      cur      <= '{kind: kind_none, length: 11'd0};
      byte_cnt <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (grant.kind != kind_none) begin
            cur   <= grant;
            state <= st_request;
          end
        end
        st_request: begin
          if (udp_tx_enable) begin  // first byte goes out next cycle
            state    <= st_send;
            byte_cnt <= '0;
          end
        end
        st_send: begin
          if (last_byte) state <= st_idle;
          else byte_cnt <= next_idx;
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_request) data_q <= sync_hi;
    else if ((state == st_send) && !last_byte) data_q <= next_byte;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      iq_seq   <= '0;
      spec_seq <= '0;
    end else if (!run) begin
      iq_seq   <= '0;
      spec_seq <= '0;
    end else if ((state == st_send) && last_byte) begin
      if (cur.kind == kind_iq) iq_seq <= iq_seq + 32'd1;
      if (cur.kind == kind_spec) spec_seq <= spec_seq + 32'd1;
    end
  end

  // arbiter and framer must agree on the payload size
  a_stream_len: assert property (@(posedge clk) disable iff (!rst_n)
    ((grant.kind == kind_iq) || (grant.kind == kind_spec))
      |-> (grant.length == 11'(hdr_bytes + payload_len)))
    else $error("streaming grant length mismatch");

endmodule

//--- verilog/us_pkg.sv
// shared types and constants; streaming frame length is hdr_bytes + payload_len and must fit 11 bits
package us_pkg;

  // frame class chosen by the arbiter
  typedef enum logic [1:0] {
    kind_none,
    kind_disc,
    kind_iq,
    kind_spec
  } frame_kind_t;

  // arbiter to framer, valid for one cycle when kind != kind_none
  typedef struct packed {
    frame_kind_t kind;
    logic [10:0] length;  // whole frame in bytes
  } frame_grant_t;

  // frame sync bytes
  localparam logic [7:0] sync_hi = 8'hef;
  localparam logic [7:0] sync_lo = 8'hfe;

  // endpoint bytes of the streaming classes
  localparam logic [7:0] ep_iq   = 8'h06;
  localparam logic [7:0] ep_spec = 8'h04;

  // sync 2, type 1, endpoint 1, sequence 4
  localparam int hdr_bytes = 8;

  // fixed size of a discovery reply
  localparam int disc_bytes = 60;

endpackage

//--- verilog/us_top.sv
// upstream frame packer top; FIFO writers must respect the fill level, the MAC port is byte-wide
module us_top import us_pkg::*; #(
  parameter int payload_len     = 1024,
  parameter int fifo_depth_log2 = 11
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        run,
  input  logic        wide_spectrum,
  input  logic        discovery,
  input  logic [47:0] mac,
  input  logic [7:0]  serial_no,
  input  logic [7:0]  board_id,
  input  logic [7:0]  assign_nr,
  input  logic        iq_wr,
  input  logic [7:0]  iq_wdata,
  input  logic        spec_wr,
  input  logic [7:0]  spec_wdata,
  input  logic        udp_tx_enable,
  output logic        udp_tx_request,
  output logic [7:0]  udp_tx_data,
  output logic [10:0] udp_tx_length
);

  logic [7:0]   iq_rd_data;
  logic [7:0]   spec_rd_data;
  logic [11:0]  iq_level;
  logic [11:0]  spec_level;
  logic         iq_rd;
  logic         spec_rd;
  logic         busy;
  frame_grant_t grant;

  us_byte_fifo #(.fifo_depth_log2(fifo_depth_log2)) u_iq_fifo (
    .clk, .rst_n, .wr(iq_wr), .wdata(iq_wdata), .rd(iq_rd),
    .rd_data(iq_rd_data), .level(iq_level)
  );

  us_byte_fifo #(.fifo_depth_log2(fifo_depth_log2)) u_spec_fifo (
    .clk, .rst_n, .wr(spec_wr), .wdata(spec_wdata), .rd(spec_rd),
    .rd_data(spec_rd_data), .level(spec_level)
  );

  us_arbiter #(.payload_len(payload_len)) u_arbiter (
    .clk, .rst_n, .discovery, .run, .wide_spectrum,
    .iq_level, .spec_level, .busy, .grant
  );

  us_framer #(.payload_len(payload_len)) u_framer (
    .clk, .rst_n, .run, .mac, .serial_no, .board_id, .assign_nr, .grant, .busy,
    .udp_tx_enable, .udp_tx_request, .udp_tx_data, .udp_tx_length,
    .iq_rd_data, .spec_rd_data, .iq_rd, .spec_rd
  );

endmodule
